// File: sim/rv_alu_core_golden.txt
# Columns: instruction word (hex), expected result data (hex), expected illegal flag
# Run in order from reset; text after the third column is a note
00028333 0000000000000000 0  add  x6, x5, x0
ffb00093 fffffffffffffffb 0  addi x1, x0, -5
00700113 0000000000000007 0  addi x2, x0, 7
002081b3 0000000000000002 0  add  x3, x1, x2
40208233 fffffffffffffff4 0  sub  x4, x1, x2
0020c2b3 fffffffffffffffc 0  xor  x5, x1, x2
0020e333 ffffffffffffffff 0  or   x6, x1, x2
0020f3b3 0000000000000003 0  and  x7, x1, x2
0020a433 0000000000000001 0  slt  x8, x1, x2
0020b4b3 0000000000000000 0  sltu x9, x1, x2
03f0d513 0000000000000001 0  srli x10, x1, 63
43f0d593 ffffffffffffffff 0  srai x11, x1, 63
04100613 0000000000000041 0  addi x12, x0, 65
00c116b3 000000000000000e 0  sll  x13, x2, x12
00c0d733 7ffffffffffffffd 0  srl  x14, x1, x12
40c0d7b3 fffffffffffffffd 0  sra  x15, x1, x12
ffc0a813 0000000000000001 0  slti x16, x1, -4
ffc0b893 0000000000000001 0  sltiu x17, x1, -4
fff14913 fffffffffffffff8 0  xori x18, x2, -1
0f00fa93 00000000000000f0 0  andi x21, x1, 0xf0
00510013 000000000000000c 0  addi x0, x2, 5
000009b3 0000000000000000 0  add  x19, x0, x0
000001ff 0000000000000000 1  unknown opcode, rd x3
022081b3 0000000000000000 1  funct7 0000001, rd x3
00018a33 0000000000000002 0  add  x20, x3, x0

// File: rv_alu_core.f
design/rv_isa_pkg.sv
design/alu_core_pkg.sv
design/register_file.sv
design/inst_decoder.sv
design/alu_execute.sv
design/writeback_result.sv
design/rv_alu_core.sv
sim/rv_alu_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= rv_alu_core_tb
FILELIST  ?= rv_alu_core.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/rv_alu_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv_alu_core_tb
    import rv_isa_pkg::*;
    import alu_core_pkg::*;
();

    localparam string GOLDEN_FILE = "sim/rv_alu_core_golden.txt";
    localparam int    ACK_TIMEOUT = 20;
    // One edge to accept and three more to ack
    localparam int    RISE_CYCLES = 4;
    localparam int    FALL_CYCLES = 1;

    logic         clk;
    logic         rst_n;
    logic         req;
    inst_word_u   inst;
    logic         ack;
    core_result_t result;

    logic [31:0]  inst_q[$];
    logic [63:0]  data_q[$];
    logic         illegal_q[$];
    logic [31:0]  lfsr = 32'h98ef2d56;
    int           error_count = 0;
    int           pass_count = 0;
    int           fail_count = 0;
    logic         run_aborted = 1'b0;

    rv_alu_core u_rv_alu_core (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .req_i    (req),
        .inst_i   (inst),
        .ack_o    (ack),
        .result_o (result)
    );

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // One LFSR step per bit taken
    task automatic random_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic report_test(input int num, input string label, input logic ok);
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %0d %s: %s", num, label, ok ? "ok" : "FAIL");
    endtask

    // Samples ack at falling edges and gives up after ACK_TIMEOUT cycles
    task automatic wait_ack_level(input logic level, output int cycles,
                                  output logic timed_out);
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
            seen = (ack === level);
        end
        timed_out = !seen;
    endtask

    // Instruction, expected data and expected illegal flag per line
    task automatic load_golden();
        int          fd;
        int          fields;
        string       line;
        logic [63:0] word;
        logic [63:0] data;
        logic [63:0] flag;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the golden vector file %s", GOLDEN_FILE);
            run_aborted = 1'b1;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%h %h %h", word, data, flag);
                if (fields == 3) begin
                    inst_q.push_back(word[31:0]);
                    data_q.push_back(data);
                    illegal_q.push_back(flag[0]);
                end
            end
        end
        $fclose(fd);
        if (inst_q.size() == 0) begin
            $display("The golden vector file holds no vectors");
            run_aborted = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // One four-phase transaction
    ////////////////////////////////////////////////////////////
    task automatic run_transaction(input int idx, output logic timed_out);
        logic [31:0]  word;
        logic [63:0]  exp_data;
        logic         exp_ill;
        int           cycles;
        int           gap;
        int           extra;
        int           errs_before;
        word        = inst_q[idx];
        exp_data    = data_q[idx];
        exp_ill     = illegal_q[idx];
        errs_before = error_count;
        timed_out   = 1'b0;

        // No stray ack during the idle gap
        random_bits(2, gap);
        repeat (gap) begin
            @(posedge clk);
            @(negedge clk);
            check_value({63'd0, ack}, 64'd0, "ack_o low during idle gap");
        end

        @(posedge clk);
        req  <= 1'b1;
        inst <= word;
        wait_ack_level(1'b1, cycles, timed_out);
        if (timed_out) begin
            $display("Timed out waiting for ack_o to rise for instruction %h", word);
            report_test(idx + 1, $sformatf("inst %h", word), 1'b0);
            return;
        end
        check_value(64'(cycles), 64'(RISE_CYCLES), "ack_o rise latency");
        check_value(result.data, exp_data, "result_o.data");
        check_value({63'd0, result.illegal}, {63'd0, exp_ill}, "result_o.illegal");

        // Ack and result must not move while the host holds req
        random_bits(2, extra);
        repeat (extra) begin
            @(posedge clk);
            @(negedge clk);
            check_value({63'd0, ack}, 64'd1, "ack_o held with req_i high");
            check_value(result.data, exp_data, "result_o.data held");
            check_value({63'd0, result.illegal}, {63'd0, exp_ill},
                        "result_o.illegal held");
        end

        @(posedge clk);
        req <= 1'b0;
        wait_ack_level(1'b0, cycles, timed_out);
        if (timed_out) begin
            $display("Timed out waiting for ack_o to fall for instruction %h", word);
            report_test(idx + 1, $sformatf("inst %h", word), 1'b0);
            return;
        end
        check_value(64'(cycles), 64'(FALL_CYCLES), "ack_o fall latency");
        report_test(idx + 1, $sformatf("inst %h", word), error_count == errs_before);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic timed_out;
        int   errs_before;
        rst_n = 1'b0;
        req   = 1'b0;
        inst  = '0;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        // Reset state
        errs_before = error_count;
        check_value({63'd0, ack}, 64'd0, "ack_o after reset");
        check_value(result.data, 64'd0, "result_o.data after reset");
        check_value({63'd0, result.illegal}, 64'd0, "result_o.illegal after reset");
        report_test(0, "reset state", error_count == errs_before);

        load_golden();
        for (int t = 0; t < inst_q.size() && !run_aborted; t++) begin
            run_transaction(t, timed_out);
            if (timed_out) begin
                run_aborted = 1'b1;
            end
        end

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (error_count == 0 && fail_count == 0 && !run_aborted) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/rv_alu_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_alu_core
    import rv_isa_pkg::*;
    import alu_core_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    // Four-phase host port
    input  wire logic       req_i,
    input  wire inst_word_u inst_i,
    output logic            ack_o,
    output core_result_t    result_o
);

    reg_idx_t    rs1_idx;
    reg_idx_t    rs2_idx;
    reg_idx_t    rd_idx;
    xlen_t       rs1_data;
    xlen_t       rs2_data;
    xlen_t       rd_data;
    logic        rd_wr_en;
    logic        uop_valid;
    micro_op_t   uop;
    logic        res_valid;
    exe_result_t res;

    ////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////
    inst_decoder u_inst_decoder (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .inst_i      (inst_i),
        .ack_i       (ack_o),
        .rs1_idx_o   (rs1_idx),
        .rs2_idx_o   (rs2_idx),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .uop_valid_o (uop_valid),
        .uop_o       (uop)
    );

    alu_execute u_alu_execute (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .uop_valid_i (uop_valid),
        .uop_i       (uop),
        .res_valid_o (res_valid),
        .res_o       (res)
    );

    writeback_result u_writeback_result (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .res_valid_i (res_valid),
        .res_i       (res),
        .rd_idx_o    (rd_idx),
        .rd_wr_en_o  (rd_wr_en),
        .rd_data_o   (rd_data),
        .req_i       (req_i),
        .ack_o       (ack_o),
        .result_o    (result_o)
    );

    // Register file beside the stages
    register_file u_register_file (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_idx_i  (rs1_idx),
        .rs2_idx_i  (rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .rd_idx_i   (rd_idx),
        .wr_en_i    (rd_wr_en),
        .wr_data_i  (rd_data)
    );

endmodule

`default_nettype wire

// File: design/writeback_result.sv
`timescale 1ns/100ps
`default_nettype none

module writeback_result
    import alu_core_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    // From execute
    input  wire logic        res_valid_i,
    input  wire exe_result_t res_i,
    // Register file write port
    output reg_idx_t         rd_idx_o,
    output logic             rd_wr_en_o,
    output xlen_t            rd_data_o,
    // Host acknowledge side
    input  wire logic        req_i,
    output logic             ack_o,
    output core_result_t     result_o
);

    // Write lands on the same edge that raises ack
    assign rd_idx_o   = res_i.rd_idx;
    assign rd_data_o  = res_i.rd_data;
    assign rd_wr_en_o = res_valid_i && res_i.rd_wr_en;

    ////////////////////////////////////////////////////////////
    // Acknowledge and returned value
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o    <= 1'b0;
            result_o <= '0;
        end else begin
            if (res_valid_i) begin
                ack_o            <= 1'b1;
                result_o.data    <= res_i.rd_data;
                result_o.illegal <= res_i.illegal;
            end else if (ack_o && !req_i) begin
                // Host dropped req, close out
                ack_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/alu_execute.sv
`timescale 1ns/100ps
`default_nettype none

module alu_execute
    import alu_core_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    // From decode
    input  wire logic      uop_valid_i,
    input  wire micro_op_t uop_i,
    // To result stage
    output logic           res_valid_o,
    output exe_result_t    res_o
);

    logic [ALU_OP_W-1:0] op;
    logic [SHAMT_W-1:0]  shamt;
    logic                lt_s;
    logic                lt_u;
    xlen_t               a;
    xlen_t               b;
    xlen_t               alu_res;

    assign op    = uop_i.alu_op_1h;
    assign a     = uop_i.op_a;
    assign b     = uop_i.op_b;
    // Only the low six bits count as shift amount
    assign shamt = b[SHAMT_W-1:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    ////////////////////////////////////////////////////////////
    // One-hot AND-OR result select
    ////////////////////////////////////////////////////////////
    // Illegal uop arrives with op all zero, so data is zero
    always_comb begin
        alu_res = ({XLEN{op[ALU_ADD]}}  & (a + b))
                | ({XLEN{op[ALU_SUB]}}  & (a - b))
                | ({XLEN{op[ALU_SLL]}}  & (a << shamt))
                | ({XLEN{op[ALU_SLT]}}  & {{(XLEN-1){1'b0}}, lt_s})
                | ({XLEN{op[ALU_SLTU]}} & {{(XLEN-1){1'b0}}, lt_u})
                | ({XLEN{op[ALU_XOR]}}  & (a ^ b))
                | ({XLEN{op[ALU_SRL]}}  & (a >> shamt))
                | ({XLEN{op[ALU_SRA]}}  & xlen_t'($signed(a) >>> shamt))
                | ({XLEN{op[ALU_OR]}}   & (a | b))
                | ({XLEN{op[ALU_AND]}}  & (a & b));
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= uop_valid_i;
        end
    end

    // Result payload
    always_ff @(posedge clk_i) begin
        if (uop_valid_i) begin
            res_o.rd_idx   <= uop_i.rd_idx;
            res_o.rd_wr_en <= uop_i.rd_wr_en;
            res_o.rd_data  <= alu_res;
            res_o.illegal  <= uop_i.illegal;
        end
    end

endmodule

`default_nettype wire

// File: design/inst_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decoder
    import rv_isa_pkg::*;
    import alu_core_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    // Host request side
    input  wire logic       req_i,
    input  wire inst_word_u inst_i,
    input  wire logic       ack_i,
    // Register file async read
    output reg_idx_t        rs1_idx_o,
    output reg_idx_t        rs2_idx_o,
    input  wire xlen_t      rs1_data_i,
    input  wire xlen_t      rs2_data_i,
    // To execute
    output logic            uop_valid_o,
    output micro_op_t       uop_o
);

    logic                busy_q;
    logic                acc_q;
    logic                accept;
    logic                alt;
    logic                bad;
    logic                is_imm;
    logic [ALU_OP_W-1:0] op_1h;
    xlen_t               imm_sext;
    micro_op_t           uop_d;

    ////////////////////////////////////////////////////////////
    // Handshake acceptance
    ////////////////////////////////////////////////////////////
    // Take a request only when idle
    assign accept = req_i && !busy_q;

    // Busy until req and ack both seen low, so a held req is not retaken
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q      <= 1'b0;
            acc_q       <= 1'b0;
            uop_valid_o <= 1'b0;
        end else begin
            if (accept) begin
                busy_q <= 1'b1;
            end else if (!req_i && !ack_i) begin
                busy_q <= 1'b0;
            end
            acc_q       <= accept;
            uop_valid_o <= acc_q;
        end
    end

    ////////////////////////////////////////////////////////////
    // Field decode
    ////////////////////////////////////////////////////////////
    // inst_i stays stable while req is high
    assign rs1_idx_o = inst_i.r.rs1;
    assign rs2_idx_o = inst_i.r.rs2;
    assign imm_sext  = {{(XLEN-12){inst_i.i.imm12[11]}}, inst_i.i.imm12};
    assign is_imm    = (inst_i.r.opcode == OPC_OP_IMM);

    always_comb begin
        alt   = 1'b0;
        bad   = 1'b0;
        op_1h = '0;
        if (inst_i.r.opcode == OPC_OP) begin
            alt = (inst_i.r.funct7 == F7_ALT);
            // funct7 alt only legal on ADD/SUB and SRL/SRA
            bad = !((inst_i.r.funct7 == 7'd0) ||
                    (alt && (inst_i.r.funct3 == F3_ADD_SUB ||
                             inst_i.r.funct3 == F3_SRL_SRA)));
        end else if (is_imm) begin
            // Bit 30 picks SRAI; ADDI never subtracts
            alt = (inst_i.i.funct3 == F3_SRL_SRA) && inst_i.i.imm12[10];
            // Upper six immediate bits of a shift act as funct6
            bad = ((inst_i.i.funct3 == F3_SLL) && (inst_i.i.imm12[11:6] != 6'd0)) ||
                  ((inst_i.i.funct3 == F3_SRL_SRA) &&
                   (inst_i.i.imm12[11:6] != 6'd0) &&
                   (inst_i.i.imm12[11:6] != F7_ALT[6:1]));
        end else begin
            bad = 1'b1;
        end

        case (inst_i.r.funct3)
            F3_ADD_SUB: op_1h[alt ? ALU_SUB : ALU_ADD] = 1'b1;
            F3_SLL:     op_1h[ALU_SLL]  = 1'b1;
            F3_SLT:     op_1h[ALU_SLT]  = 1'b1;
            F3_SLTU:    op_1h[ALU_SLTU] = 1'b1;
            F3_XOR:     op_1h[ALU_XOR]  = 1'b1;
            F3_SRL_SRA: op_1h[alt ? ALU_SRA : ALU_SRL] = 1'b1;
            F3_OR:      op_1h[ALU_OR]   = 1'b1;
            default:    op_1h[ALU_AND]  = 1'b1;
        endcase

        // Empty op vector makes execute return zero
        if (bad) begin
            op_1h = '0;
        end

        uop_d.alu_op_1h = op_1h;
        uop_d.op_a      = rs1_data_i;
        uop_d.op_b      = is_imm ? imm_sext : rs2_data_i;
        uop_d.rd_idx    = inst_i.r.rd;
        uop_d.rd_wr_en  = !bad;
        uop_d.illegal   = bad;
    end

    // Micro-op captured one cycle after acceptance
    always_ff @(posedge clk_i) begin
        if (acc_q) begin
            uop_o <= uop_d;
        end
    end

endmodule

`default_nettype wire

// File: design/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file
    import alu_core_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    // Read ports, combinational
    input  wire reg_idx_t rs1_idx_i,
    input  wire reg_idx_t rs2_idx_i,
    output xlen_t         rs1_data_o,
    output xlen_t         rs2_data_o,
    // Write port
    input  wire reg_idx_t rd_idx_i,
    input  wire logic     wr_en_i,
    input  wire xlen_t    wr_data_i
);

    xlen_t regs [NUM_REGS];

    // x0 reads as zero whatever the array holds
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (rd_idx_i != '0)) begin
            // Writes to x0 dropped
            regs[rd_idx_i] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

// File: design/alu_core_pkg.sv
`default_nettype none

package alu_core_pkg;

    localparam int XLEN      = 64;
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS  = 32;
    // RV64 shifts use 6 bits of shamt
    localparam int SHAMT_W   = 6;

    ////////////////////////////////////////////////////////////
    // One-hot ALU operation bit positions
    ////////////////////////////////////////////////////////////
    localparam int ALU_OP_W  = 10;
    localparam int ALU_ADD   = 0;
    localparam int ALU_SUB   = 1;
    localparam int ALU_SLL   = 2;
    localparam int ALU_SLT   = 3;
    localparam int ALU_SLTU  = 4;
    localparam int ALU_XOR   = 5;
    localparam int ALU_SRL   = 6;
    localparam int ALU_SRA   = 7;
    localparam int ALU_OR    = 8;
    localparam int ALU_AND   = 9;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [XLEN-1:0]      xlen_t;

    // Decode -> execute
    typedef struct packed {
        logic [ALU_OP_W-1:0] alu_op_1h;
        xlen_t               op_a;
        xlen_t               op_b;
        reg_idx_t            rd_idx;
        logic                rd_wr_en;
        logic                illegal;
    } micro_op_t;

    // Execute -> result stage
    typedef struct packed {
        reg_idx_t rd_idx;
        logic     rd_wr_en;
        xlen_t    rd_data;
        logic     illegal;
    } exe_result_t;

    // Returned to the host with ack
    typedef struct packed {
        xlen_t data;
        logic  illegal;
    } core_result_t;

endpackage

`default_nettype wire

// File: design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    ////////////////////////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////////////////////////
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3 codes, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Alternate funct7, picks SUB / SRA
    localparam logic [6:0] F7_ALT     = 7'b0100000;

    ////////////////////////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    // Same 32 bits, R view for rs2/funct7, I view for the immediate
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_word_u;

endpackage

`default_nettype wire
